/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_dcache
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT  = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* block_access.svh */
// lane select inside a 64-bit block by the low three address bits
function automatic word_t read_lanes(input block_t block, input logic [2:0] offset,
                                     input access_size_t size);
    word_t result;
    result = '0;
    case (size)
        size_byte: result[7:0] = block[{offset, 3'b000} +: 8];
        size_half: result[15:0] = block[{offset[2:1], 4'b0000} +: 16];
        size_word: result = block[{offset[2], 5'b00000} +: 32];
        default:   result = '0;
    endcase
    return result;
endfunction

// store merge that changes only the addressed lanes
function automatic block_t merge_lanes(input block_t block, input logic [2:0] offset,
                                       input access_size_t size, input word_t data);
    block_t merged;
    merged = block;
    case (size)
        size_byte: merged[{offset, 3'b000} +: 8] = data[7:0];
        size_half: merged[{offset[2:1], 4'b0000} +: 16] = data[15:0];
        size_word: merged[{offset[2], 5'b00000} +: 32] = data;
        default:   merged = block;
    endcase
    return merged;
endfunction

/* build.f */
+incdir+.
cache_pkg.sv
mem_bus_pkg.sv
main_cache.sv
victim_cache.sv
miss_table.sv
dcache_control.sv
dcache_top.sv
tb_memory.sv
tb_dcache.sv

/* cache_pkg.sv */
package cache_pkg;

    typedef logic [31:0] addr_t;        // byte address
    typedef logic [31:0] word_t;        // load result, zero-extended
    typedef logic [63:0] block_t;       // one cache line
    typedef logic [28:0] line_addr_t;   // byte address without offset bits

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } access_size_t;

    typedef enum logic {
        op_read,
        op_write
    } mem_op_t;

    typedef struct packed {
        logic         valid;
        mem_op_t      op;
        access_size_t size;
        addr_t        addr;
        word_t        data;   // store data, low lanes used for byte and half
    } cache_request_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } cache_response_t;

    typedef struct packed {
        logic       valid;
        logic       dirty;
        line_addr_t line;   // full line address doubles as the tag
        block_t     block;
    } cache_line_t;

    // returning read line from memory
    typedef struct packed {
        logic       valid;
        line_addr_t line;
        block_t     block;
    } fill_t;

endpackage

/* dcache_control.sv */
`timescale 1ns/100ps

module dcache_control
    import cache_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  cache_request_t  request,
    output logic            request_ready,
    output cache_response_t response,
    output cache_request_t  lookup,
    input  logic            main_hit,
    input  logic            victim_hit,
    input  block_t          main_data,
    input  block_t          victim_data,
    input  fill_t           fill,
    input  logic            slot_free,
    output line_addr_t      miss_line,
    output logic            miss_alloc
);

    `include "block_access.svh"

    typedef enum logic [1:0] {
        st_idle,
        st_wait_slot,   // miss seen, no free miss table entry yet
        st_wait_fill,
        st_replay       // lookup again once the line is installed
    } state_t;

    state_t          state;
    state_t          next_state;
    cache_request_t  held;      // the missed request
    cache_response_t next_response;
    block_t          hit_block;
    logic            any_hit;
    logic            miss;
    logic            fill_match;

    assign request_ready = (state == st_idle);

    always_comb begin
        case (state)
            st_idle: begin
                lookup       = request;
                lookup.valid = request.valid & request_ready;
            end
            st_replay: lookup = held;
            default:   lookup = '0;
        endcase
    end

    assign any_hit    = main_hit | victim_hit;
    assign hit_block  = main_hit ? main_data : victim_data;  // main cache wins
    assign miss       = (state == st_idle) & request.valid & ~any_hit;
    assign miss_line  = (state == st_idle) ? request.addr[31:3] : held.addr[31:3];
    assign miss_alloc = (miss | (state == st_wait_slot)) & slot_free;
    assign fill_match = fill.valid & (fill.line == held.addr[31:3]);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (miss) begin
                    next_state = slot_free ? st_wait_fill : st_wait_slot;
                end
            end
            st_wait_slot: begin
                if (slot_free) begin
                    next_state = st_wait_fill;
                end
            end
            st_wait_fill: begin
                if (fill_match) begin
                    next_state = st_replay;
                end
            end
            default: next_state = st_idle;     // replay always hits
        endcase
    end

    always_comb begin
        next_response.valid = lookup.valid & any_hit;
        next_response.data  = '0;
        if (lookup.op == op_read) begin
            next_response.data = read_lanes(hit_block, lookup.addr[2:0], lookup.size);
        end
    end

    always_ff @(posedge clock) begin
        response.data <= next_response.data;
        if (miss) begin
            held <= request;
        end
        if (reset) begin
            state          <= st_idle;
            response.valid <= 1'b0;
        end else begin
            state          <= next_state;
            response.valid <= next_response.valid;
        end
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/100ps

module dcache_top
    import cache_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int n_lines  = 16,
    parameter int n_victim = 4,
    parameter int n_mshr   = 4
) (
    input  logic            clock,
    input  logic            reset,
    input  cache_request_t  request,
    output logic            request_ready,
    output cache_response_t response,
    output mem_request_t    mem_request,
    input  mem_reply_t      mem_reply
);

    cache_request_t lookup;     // shared by both caches
    logic           main_hit;
    logic           victim_hit;
    block_t         main_data;
    block_t         victim_data;
    fill_t          fill;
    cache_line_t    evicted;    // main cache -> victim cache
    cache_line_t    writeback;  // victim cache -> miss table, dirty only
    logic           slot_free;
    line_addr_t     miss_line;
    logic           miss_alloc;

    dcache_control control_i (
        .clock         (clock),
        .reset         (reset),
        .request       (request),
        .request_ready (request_ready),
        .response      (response),
        .lookup        (lookup),
        .main_hit      (main_hit),
        .victim_hit    (victim_hit),
        .main_data     (main_data),
        .victim_data   (victim_data),
        .fill          (fill),
        .slot_free     (slot_free),
        .miss_line     (miss_line),
        .miss_alloc    (miss_alloc)
    );

    main_cache #(.n_lines(n_lines)) main_cache_i (
        .clock    (clock),
        .reset    (reset),
        .lookup   (lookup),
        .hit      (main_hit),
        .hit_data (main_data),
        .fill     (fill),
        .evicted  (evicted)
    );

    victim_cache #(.n_victim(n_victim)) victim_cache_i (
        .clock     (clock),
        .reset     (reset),
        .lookup    (lookup),
        .hit       (victim_hit),
        .hit_data  (victim_data),
        .incoming  (evicted),
        .writeback (writeback)
    );

    miss_table #(.n_mshr(n_mshr)) miss_table_i (
        .clock       (clock),
        .reset       (reset),
        .miss_line   (miss_line),
        .miss_alloc  (miss_alloc),
        .slot_free   (slot_free),
        .writeback   (writeback),
        .fill        (fill),
        .mem_request (mem_request),
        .mem_reply   (mem_reply)
    );

endmodule

/* main_cache.sv */
`timescale 1ns/100ps

module main_cache
    import cache_pkg::*;
#(
    parameter int n_lines = 16
) (
    input  logic           clock,
    input  logic           reset,
    input  cache_request_t lookup,
    output logic           hit,
    output block_t         hit_data,
    input  fill_t          fill,
    output cache_line_t    evicted
);

    `include "block_access.svh"

    localparam int index_bits = $clog2(n_lines);

    typedef logic [index_bits-1:0] index_t;

    cache_line_t lines [n_lines];
    line_addr_t  lookup_line;
    index_t      lookup_index;
    index_t      fill_index;

    assign lookup_line  = lookup.addr[31:3];
    assign lookup_index = lookup_line[index_bits-1:0];
    assign fill_index   = fill.line[index_bits-1:0];

    // full line address compare, the index bits are checked too
    assign hit = lookup.valid & lines[lookup_index].valid
               & (lines[lookup_index].line == lookup_line);
    assign hit_data = lines[lookup_index].block;

    always_comb begin
        evicted       = lines[fill_index];
        evicted.valid = fill.valid & lines[fill_index].valid;  // old line goes to victim cache
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < n_lines; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else begin
            if (hit && lookup.op == op_write) begin
                lines[lookup_index].dirty <= 1'b1;
                lines[lookup_index].block <= merge_lanes(lines[lookup_index].block,
                                                         lookup.addr[2:0], lookup.size,
                                                         lookup.data);
            end
            // fill installs clean
            if (fill.valid) begin
                lines[fill_index].valid <= 1'b1;
                lines[fill_index].dirty <= 1'b0;
                lines[fill_index].line  <= fill.line;
                lines[fill_index].block <= fill.block;
            end
        end
    end

endmodule

/* mem_bus_pkg.sv */
package mem_bus_pkg;

    import cache_pkg::*;

    typedef enum logic [1:0] {
        bus_none,
        bus_load,
        bus_store
    } bus_command_t;

    typedef logic [3:0] mem_tag_t;  // zero means no transaction

    typedef struct packed {
        bus_command_t command;
        addr_t        addr;     // line aligned
        block_t       data;
    } mem_request_t;

    typedef struct packed {
        mem_tag_t accept_tag;   // nonzero when the held command is taken
        mem_tag_t fill_tag;     // nonzero when load data returns
        block_t   fill_data;
    } mem_reply_t;

endpackage

/* miss_table.sv */
`timescale 1ns/100ps

module miss_table
    import cache_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int n_mshr = 4
) (
    input  logic         clock,
    input  logic         reset,
    input  line_addr_t   miss_line,
    input  logic         miss_alloc,
    output logic         slot_free,
    input  cache_line_t  writeback,
    output fill_t        fill,
    output mem_request_t mem_request,
    input  mem_reply_t   mem_reply
);

    localparam int index_bits = $clog2(n_mshr);

    typedef logic [index_bits-1:0] slot_t;

    typedef struct packed {
        logic       valid;
        mem_op_t    op;
        line_addr_t line;
        block_t     block;  // write-back data, unused by reads
        mem_tag_t   tag;    // zero until memory accepts a load
    } entry_t;

    entry_t entries [n_mshr];
    entry_t next_entries [n_mshr];
    logic   issue_valid;
    slot_t  issue_index;
    logic   write_placed;
    logic   read_placed;

    // untagged entries only; second loop lets writes override reads
    always_comb begin
        issue_valid = 1'b0;
        issue_index = '0;
        slot_free   = 1'b0;
        for (int i = n_mshr - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].tag == '0 && entries[i].op == op_read) begin
                issue_valid = 1'b1;
                issue_index = slot_t'(i);
            end
            if (!entries[i].valid) begin
                slot_free = 1'b1;
            end
        end
        for (int i = n_mshr - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].tag == '0 && entries[i].op == op_write) begin
                issue_valid = 1'b1;
                issue_index = slot_t'(i);
            end
        end
    end

    always_comb begin
        mem_request.command = bus_none;
        if (issue_valid) begin
            mem_request.command = (entries[issue_index].op == op_write) ? bus_store : bus_load;
        end
        mem_request.addr = {entries[issue_index].line, 3'b000};
        mem_request.data = entries[issue_index].block;
    end

    always_comb begin
        next_entries = entries;
        fill         = '0;
        write_placed = 1'b0;
        read_placed  = 1'b0;
        // only loads hold a nonzero tag
        for (int i = 0; i < n_mshr; i++) begin
            if (mem_reply.fill_tag != '0 && entries[i].valid
                && entries[i].tag == mem_reply.fill_tag) begin
                fill.valid            = 1'b1;
                fill.line             = entries[i].line;
                fill.block            = mem_reply.fill_data;
                next_entries[i].valid = 1'b0;
            end
        end
        if (issue_valid && mem_reply.accept_tag != '0) begin
            if (entries[issue_index].op == op_write) begin
                next_entries[issue_index].valid = 1'b0;     // memory wrote it on accept
            end else begin
                next_entries[issue_index].tag = mem_reply.accept_tag;
            end
        end
        // slots freed this cycle may be reused at once
        for (int i = 0; i < n_mshr; i++) begin
            if (writeback.valid && !write_placed && !next_entries[i].valid) begin
                next_entries[i].valid = 1'b1;
                next_entries[i].op    = op_write;
                next_entries[i].line  = writeback.line;
                next_entries[i].block = writeback.block;
                next_entries[i].tag   = '0;
                write_placed          = 1'b1;
            end
        end
        for (int i = 0; i < n_mshr; i++) begin
            if (miss_alloc && !read_placed && !next_entries[i].valid) begin
                next_entries[i].valid = 1'b1;
                next_entries[i].op    = op_read;
                next_entries[i].line  = miss_line;
                next_entries[i].block = '0;
                next_entries[i].tag   = '0;
                read_placed           = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < n_mshr; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= next_entries;
        end
    end

endmodule

/* tb_dcache.sv */
`timescale 1ns/100ps

module tb_dcache
    import cache_pkg::*;
    import mem_bus_pkg::*;
();

    localparam addr_t window_base    = 32'h0000_4000;
    localparam int    ready_limit    = 200;
    localparam int    response_limit = 400;
    localparam int    t_reset        = 0;
    localparam int    t_load         = 1;
    localparam int    t_count        = 2;
    localparam int    t_timing       = 3;
    localparam int    t_writeback    = 4;
    localparam int    t_refusal      = 5;

    logic            clock;
    logic            reset;
    cache_request_t  request;
    logic            request_ready;
    cache_response_t response;
    mem_request_t    mem_request;
    mem_reply_t      mem_reply;
    logic            refuse_enable;

    logic [7:0]  model [512];   // byte image of the window
    logic [31:0] rng_state;
    bit          timed_out;
    bit          refusal_phase;
    int          accepted_count;
    int          response_count;
    int          tests_passed;
    int          tests_failed;
    int          checks [6];
    int          errors [6];

    dcache_top #(.n_lines(16), .n_victim(4), .n_mshr(4)) dcache_top_i (
        .clock         (clock),
        .reset         (reset),
        .request       (request),
        .request_ready (request_ready),
        .response      (response),
        .mem_request   (mem_request),
        .mem_reply     (mem_reply)
    );

    tb_memory memory_i (
        .clock         (clock),
        .mem_request   (mem_request),
        .mem_reply     (mem_reply),
        .refuse_enable (refuse_enable)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [7:0] initial_byte(input addr_t addr);
        logic [31:0] mixed;
        mixed = addr * 32'h9e3779b1;
        return mixed[31:24];
    endfunction

    function automatic string test_name(input int t);
        case (t)
            t_reset:     return "reset_state";
            t_load:      return "load_data";
            t_count:     return "response_count";
            t_timing:    return "hit_timing";
            t_writeback: return "write_back";
            default:     return "refusal_data";
        endcase
    endfunction

    // little-endian lanes, zero-extended
    function automatic word_t expected_load(input addr_t addr, input access_size_t size);
        int base;
        base = int'(addr[8:0]);
        case (size)
            size_byte: return {24'h0, model[base]};
            size_half: return {16'h0, model[base + 1], model[base]};
            default:   return {model[base + 3], model[base + 2], model[base + 1], model[base]};
        endcase
    endfunction

    function automatic block_t model_block(input addr_t addr);
        block_t block;
        int     base;
        base = int'({addr[8:3], 3'b000});
        for (int k = 0; k < 8; k++) begin
            block[k * 8 +: 8] = model[base + k];
        end
        return block;
    endfunction

    task automatic apply_store(input cache_request_t req);
        int base;
        int count;
        base  = int'(req.addr[8:0]);
        count = (req.size == size_byte) ? 1 : (req.size == size_half) ? 2 : 4;
        for (int k = 0; k < count; k++) begin
            model[base + k] = req.data[k * 8 +: 8];
        end
    endtask

    task automatic make_request(input int store_weight, input bit have_prev,
                                input addr_t prev_addr, output cache_request_t req,
                                output bit expect_hit);
        logic [31:0] r;
        logic [31:0] hi;
        r  = next_random();
        hi = next_random() >> 16;
        req        = '0;
        req.valid  = 1'b1;
        case (r[21:20])
            2'd0:    req.size = size_byte;
            2'd1:    req.size = size_half;
            default: req.size = size_word;
        endcase
        expect_hit = have_prev && r[31:30] == 2'b00;   // a quarter reread the last line
        if (expect_hit) begin
            req.op   = op_read;
            req.addr = {prev_addr[31:3], hi[2:0]};
        end else begin
            req.op   = ((int'(r[29:23]) % 100) < store_weight) ? op_write : op_read;
            req.addr = window_base + {23'b0, hi[8:0]};
        end
        if (req.size == size_half) req.addr[0] = 1'b0;
        if (req.size == size_word) req.addr[1:0] = 2'b00;
        req.data = next_random();
    endtask

    task automatic check_response(input cache_request_t req, input bit expect_hit,
                                  input int latency);
        word_t expected;
        int    test;
        if (expect_hit) begin
            checks[t_timing]++;
            if (latency != 1) begin
                errors[t_timing]++;
                $display("** Error [hit_timing] addr 0x%h latency expected 1 actual %0d",
                         req.addr, latency);
            end
        end
        if (req.op == op_write) begin
            apply_store(req);   // store takes effect when it completes
        end else begin
            test     = refusal_phase ? t_refusal : t_load;
            expected = expected_load(req.addr, req.size);
            checks[test]++;
            if (response.data !== expected) begin
                errors[test]++;
                $display("** Error [%s] load 0x%h expected 0x%h actual 0x%h",
                         test_name(test), req.addr, expected, response.data);
            end
        end
    endtask

    // one request at a time, inputs change on the falling edge
    task automatic run_phase(input int n_requests, input int store_weight);
        cache_request_t current;
        bit             outstanding;
        bit             expect_hit;
        bit             have_prev;
        int             issued;
        int             latency;
        int             idle_wait;
        current     = '0;
        outstanding = 1'b0;
        expect_hit  = 1'b0;
        have_prev   = 1'b0;
        issued      = 0;
        latency     = 0;
        idle_wait   = 0;
        while ((issued < n_requests || outstanding) && !timed_out) begin
            @(negedge clock);
            if (outstanding) latency++;
            if (response.valid) begin
                response_count++;
                checks[t_count]++;
                if (!outstanding) begin
                    errors[t_count]++;
                    $display("response at %0t without a pending request", $time);
                end else begin
                    check_response(current, expect_hit, latency);
                    outstanding = 1'b0;
                    have_prev   = 1'b1;
                end
            end
            if (outstanding) begin
                request.valid = 1'b0;
                if (latency > response_limit) begin
                    $display("no response to the request at 0x%h within %0d cycles",
                             current.addr, response_limit);
                    timed_out = 1'b1;
                end
            end else if (issued < n_requests && request_ready) begin
                make_request(store_weight, have_prev, current.addr, current, expect_hit);
                request = current;
                accepted_count++;
                issued++;
                outstanding = 1'b1;
                latency     = 0;
                idle_wait   = 0;
            end else begin
                request.valid = 1'b0;
                idle_wait++;
                if (idle_wait > ready_limit) begin
                    $display("request_ready stayed low for %0d cycles", ready_limit);
                    timed_out = 1'b1;
                end
            end
        end
        request.valid = 1'b0;
    endtask

    task automatic report_test(input int t);
        if (errors[t] == 0 && checks[t] > 0) begin
            tests_passed++;
            $display("test %s: ok, %0d checks", test_name(t), checks[t]);
        end else begin
            tests_failed++;
            $display("test %s: FAILED, %0d errors in %0d checks", test_name(t), errors[t],
                     checks[t]);
        end
    endtask

    // write-backs must carry the line as the model holds it
    always @(negedge clock) begin
        if (!reset && mem_request.command == bus_store) begin
            checks[t_writeback]++;
            if (mem_request.addr[2:0] != 3'b000 || (mem_request.addr & ~32'h1ff) != window_base) begin
                errors[t_writeback]++;
                $display("** Error [write_back] address expected a line of 0x%h actual 0x%h",
                         window_base, mem_request.addr);
            end else if (mem_request.data !== model_block(mem_request.addr)) begin
                errors[t_writeback]++;
                $display("** Error [write_back] line 0x%h expected 0x%h actual 0x%h",
                         mem_request.addr, model_block(mem_request.addr), mem_request.data);
            end
        end
    end

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        request        = '0;
        refuse_enable  = 1'b0;
        rng_state      = 32'h7110ea28;
        timed_out      = 1'b0;
        refusal_phase  = 1'b0;
        accepted_count = 0;
        response_count = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        for (int t = 0; t < 6; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        for (int i = 0; i < 512; i++) begin
            model[i] = initial_byte(window_base + addr_t'(i));
        end
        repeat (4) @(negedge clock);
        reset = 1'b0;

        checks[t_reset] = 3;
        if (request_ready !== 1'b1) begin
            errors[t_reset]++;
            $display("** Error [reset_state] request_ready expected 1 actual %b", request_ready);
        end
        if (response.valid !== 1'b0) begin
            errors[t_reset]++;
            $display("** Error [reset_state] response valid expected 0 actual %b",
                     response.valid);
        end
        if (mem_request.command !== bus_none) begin
            errors[t_reset]++;
            $display("** Error [reset_state] command expected %0d actual %0d", bus_none,
                     mem_request.command);
        end
        report_test(t_reset);

        run_phase(600, 40);
        @(posedge clock);
        refuse_enable = 1'b1;   // memory side only, kept off the falling edge
        refusal_phase = 1'b1;
        for (int round = 0; round < 2; round++) begin
            run_phase(250, 90); // mostly stores, dirty lines pile up
            run_phase(250, 10);
        end

        checks[t_count]++;
        if (accepted_count != response_count) begin
            errors[t_count]++;
            $display("** Error [response_count] responses expected %0d actual %0d",
                     accepted_count, response_count);
        end
        for (int t = 1; t < 6; t++) begin
            report_test(t);
        end
        if (timed_out) begin
            $display("run stopped early by a timeout");
        end
        $display("summary: %0d tests ok, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb_memory.sv */
`timescale 1ns/100ps

module tb_memory
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic         clock,
    input  mem_request_t mem_request,
    output mem_reply_t   mem_reply,
    input  logic         refuse_enable  // refuse about one command in four
);

    localparam addr_t window_base = 32'h0000_4000;

    block_t      storage [64];      // one block per line of the 512-byte window
    mem_tag_t    next_tag;
    mem_tag_t    pending_tag [$];
    block_t      pending_data [$];
    int          pending_due [$];
    int          cycle;
    int          ready_index;
    int          slot;
    logic [31:0] rng_state;
    logic [31:0] roll;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // power-on content, a hash of the full byte address
    function automatic logic [7:0] initial_byte(input addr_t addr);
        logic [31:0] mixed;
        mixed = addr * 32'h9e3779b1;
        return mixed[31:24];
    endfunction

    initial begin
        rng_state = 32'h7110ea28;
        next_tag  = 4'd1;
        cycle     = 0;
        mem_reply = '0;
        for (int i = 0; i < 512; i++) begin
            storage[i / 8][(i % 8) * 8 +: 8] = initial_byte(window_base + addr_t'(i));
        end
    end

    // replies change on the falling edge, the miss table samples them on the rising edge
    always @(negedge clock) begin
        cycle++;
        mem_reply.fill_tag  = '0;
        mem_reply.fill_data = '0;
        ready_index = -1;
        for (int i = pending_due.size() - 1; i >= 0; i--) begin
            if (pending_due[i] <= cycle) begin
                ready_index = i;    // oldest due load wins
            end
        end
        if (ready_index >= 0) begin
            mem_reply.fill_tag  = pending_tag[ready_index];
            mem_reply.fill_data = pending_data[ready_index];
            pending_tag.delete(ready_index);
            pending_data.delete(ready_index);
            pending_due.delete(ready_index);
        end
        roll = next_random();
        mem_reply.accept_tag = '0;
        if (mem_request.command != bus_none && !(refuse_enable && roll[31:30] == 2'b00)) begin
            slot = int'(mem_request.addr[8:3]);
            mem_reply.accept_tag = next_tag;
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            if (mem_request.command == bus_store) begin
                storage[slot] = mem_request.data;   // written at acceptance
            end else begin
                pending_tag.push_back(mem_reply.accept_tag);
                pending_data.push_back(storage[slot]);
                pending_due.push_back(cycle + 1 + int'(roll[26:24]));  // 1 to 8 cycles
            end
        end
    end

endmodule

/* victim_cache.sv */
`timescale 1ns/100ps

module victim_cache
    import cache_pkg::*;
#(
    parameter int n_victim = 4
) (
    input  logic           clock,
    input  logic           reset,
    input  cache_request_t lookup,
    output logic           hit,
    output block_t         hit_data,
    input  cache_line_t    incoming,
    output cache_line_t    writeback
);

    `include "block_access.svh"

    localparam int index_bits = $clog2(n_victim);

    typedef logic [index_bits-1:0] index_t;
    typedef logic [index_bits-1:0] lru_t;   // highest value is most recent

    cache_line_t entries [n_victim];
    lru_t        lru [n_victim];
    line_addr_t  lookup_line;
    index_t      hit_index;
    index_t      free_index;
    index_t      oldest_index;
    index_t      place_index;
    logic        has_free;

    assign lookup_line = lookup.addr[31:3];

    always_comb begin
        hit        = 1'b0;
        hit_index  = '0;
        has_free   = 1'b0;
        free_index = '0;
        // scan downwards so the lowest index is left
        for (int i = n_victim - 1; i >= 0; i--) begin
            if (lookup.valid && entries[i].valid && entries[i].line == lookup_line) begin
                hit       = 1'b1;
                hit_index = index_t'(i);
            end
            if (!entries[i].valid) begin
                has_free   = 1'b1;
                free_index = index_t'(i);
            end
        end
        oldest_index = '0;
        for (int i = 1; i < n_victim; i++) begin
            if (lru[i] < lru[oldest_index]) begin   // strict, first index on ties
                oldest_index = index_t'(i);
            end
        end
    end

    assign hit_data    = entries[hit_index].block;
    assign place_index = has_free ? free_index : oldest_index;

    always_comb begin
        writeback       = entries[oldest_index];
        writeback.valid = incoming.valid & ~has_free & entries[oldest_index].dirty;  // clean lines drop
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < n_victim; i++) begin
                entries[i].valid <= 1'b0;
                lru[i]           <= '0;
            end
        end else begin
            if (hit) begin
                for (int i = 0; i < n_victim; i++) begin
                    if (index_t'(i) == hit_index) begin
                        lru[i] <= '1;
                    end else if (lru[i] != '0) begin
                        lru[i] <= lru[i] - 1'b1;
                    end
                end
                if (lookup.op == op_write) begin
                    entries[hit_index].dirty <= 1'b1;
                    entries[hit_index].block <= merge_lanes(entries[hit_index].block,
                                                            lookup.addr[2:0], lookup.size,
                                                            lookup.data);
                end
            end
            if (incoming.valid) begin
                for (int i = 0; i < n_victim; i++) begin
                    if (index_t'(i) == place_index) begin
                        lru[i] <= '1;
                    end else if (lru[i] != '0) begin
                        lru[i] <= lru[i] - 1'b1;
                    end
                end
                entries[place_index] <= incoming;
            end
        end
    end

endmodule
